// File: apbLoader.sv
`default_nettype none

`include "fetch_params.svh"

module apbLoader (
    input  logic                   Clock,
    input  logic                   i_arstN,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [7:0]             i_paddr,
    input  logic [`DATA_W-1:0]     i_pwdata,
    output logic [`DATA_W-1:0]     o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    output logic                   o_push,          // One-cycle append pulse
    output logic [`DATA_W-1:0]     o_pushData,
    output logic                   o_clear,         // One-cycle clear pulse
    input  logic                   i_full,
    input  logic                   i_empty,
    input  logic [`IMEM_IDX_W-1:0] i_count,
    input  logic [`DATA_W-1:0]     i_pc
);

    logic               setup;                      // First APB cycle
    logic               access;                     // Second APB cycle, transfer ends
    logic               hitData;
    logic               hitCtrl;
    logic               hitStatus;
    logic               hitPc;
    logic               mapped;
    logic [`DATA_W-1:0] statusWord;

    assign setup  = i_psel && !i_penable;
    assign access = i_psel && i_penable;

    // Register map decode
    assign hitData   = (i_paddr == `REG_DATA);
    assign hitCtrl   = (i_paddr == `REG_CTRL);
    assign hitStatus = (i_paddr == `REG_STATUS);
    assign hitPc     = (i_paddr == `REG_PC);
    assign mapped    = hitData || hitCtrl || hitStatus || hitPc;

    // Pulses armed in setup so the memory updates on the edge ending access
    always_ff @(posedge Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            o_push  <= 1'b0;
            o_clear <= 1'b0;
        end else begin
            o_push  <= setup && i_pwrite && hitData && !i_full;    // Full drops the word
            o_clear <= setup && i_pwrite && hitCtrl && i_pwdata[0];
        end
    end

    assign o_pushData = i_pwdata;                   // Held stable through access by APB

    assign o_pready = 1'b1;                         // Zero wait states

    // Error on unmapped address or a word pushed into a full memory
    assign o_pslverr = access && (!mapped || (i_pwrite && hitData && i_full));

    always_comb begin
        statusWord       = '0;
        statusWord[0]    = i_full;
        statusWord[1]    = i_empty;
        statusWord[14:8] = i_count;
    end

    always_comb begin
        case (i_paddr)
            `REG_STATUS: o_prdata = statusWord;
            `REG_PC:     o_prdata = i_pc;
            default:     o_prdata = '0;             // Data, control and unmapped
        endcase
    end

endmodule

`default_nettype wire

// File: fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Instruction and address width
`define DATA_W      32
// Words held by the instruction memory
`define IMEM_DEPTH  64
// Word index and fill count width, one bit wider so the count reaches IMEM_DEPTH
`define IMEM_IDX_W  7

// APB byte offsets of the loader registers
`define REG_DATA    8'h00
`define REG_CTRL    8'h04
`define REG_STATUS  8'h08
`define REG_PC      8'h0C

`endif

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,               // Special, funct field decides
        OP_J     = 6'h02,               // Jump
        OP_JAL   = 6'h03,               // Jump and link
        OP_BEQ   = 6'h04,               // Branch on equal
        OP_BNE   = 6'h05                // Branch on not equal
    } opcodeT;

    // R-type funct field, bits 5:0
    typedef enum logic [5:0] {
        FN_JR    = 6'h08,               // Jump register
        FN_JALR  = 6'h09                // Jump and link register
    } functT;

    // Next-PC mux select, {branch, jump}
    typedef enum logic [1:0] {
        PC_SEQ         = 2'b00,         // Fall through to PC+4
        PC_JUMP        = 2'b01,         // Jump target from decode
        PC_BRANCH      = 2'b10,         // Branch target from decode
        PC_BRANCH_JUMP = 2'b11          // Both raised, branch wins
    } pcSelT;

endpackage

`default_nettype wire

// File: ifStage.sv
`default_nettype none

`include "fetch_params.svh"

module ifStage (
    input  logic               Clock,
    input  logic               i_arstN,
    // APB loader port
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  logic [7:0]         i_paddr,
    input  logic [`DATA_W-1:0] i_pwdata,
    output logic [`DATA_W-1:0] o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,
    // Pipeline controls from hazard and decode
    input  logic               i_pcWrite,
    input  logic               i_enable,
    input  logic               i_halt,
    input  logic               i_flush,
    input  logic               i_jumpControl,
    input  logic [`DATA_W-1:0] i_jumpAddress,
    input  logic               i_branchFlag,
    input  logic [`DATA_W-1:0] i_branchAddress,
    // Fetch results
    output logic [`DATA_W-1:0] o_instruction,
    output logic [`DATA_W-1:0] o_pcResult,
    output logic [`DATA_W-1:0] o_pcPlus4,
    output logic               o_isBranch,
    output logic               o_isJump,
    output logic               o_full,
    output logic               o_empty,
    output logic [7:0]         o_scheduledPcLsb,    // Low byte of next PC
    output fetch_pkg::pcSelT   o_pcSel
);

    logic [`DATA_W-1:0]    pcNext;                  // Scheduled PC
    logic                  push;
    logic [`DATA_W-1:0]    pushData;
    logic                  clear;
    logic [`IMEM_IDX_W-1:0] count;

    programCounter u_pc (
        .Clock(Clock), .i_arstN(i_arstN),
        .i_pcWrite(i_pcWrite), .i_enable(i_enable),
        .i_halt(i_halt), .i_flush(i_flush),
        .i_pcNext(pcNext), .o_pc(o_pcResult)
    );

    nextPcSelect u_nextPc (
        .i_pc(o_pcResult),
        .i_jumpControl(i_jumpControl), .i_jumpAddress(i_jumpAddress),
        .i_branchFlag(i_branchFlag), .i_branchAddress(i_branchAddress),
        .o_pcPlus4(o_pcPlus4), .o_pcNext(pcNext), .o_pcSel(o_pcSel)
    );

    instructionMemory u_imem (
        .Clock(Clock), .i_arstN(i_arstN), .i_pc(o_pcResult),
        .i_push(push), .i_pushData(pushData), .i_clear(clear),
        .o_instruction(o_instruction), .o_isBranch(o_isBranch), .o_isJump(o_isJump),
        .o_full(o_full), .o_empty(o_empty), .o_count(count)
    );

    apbLoader u_loader (
        .Clock(Clock), .i_arstN(i_arstN),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_push(push), .o_pushData(pushData), .o_clear(clear),
        .i_full(o_full), .i_empty(o_empty), .i_count(count), .i_pc(o_pcResult)
    );

    assign o_scheduledPcLsb = pcNext[7:0];

endmodule

`default_nettype wire

// File: ifStageTb.sv
`default_nettype none

`include "fetch_params.svh"

module ifStageTb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    // Cycle budgets per test, three cycles per APB transfer
    localparam int RESET_CYCLES  = 8;
    localparam int BUDGET_LOAD   = 60;
    localparam int BUDGET_SEQ    = 30;
    localparam int BUDGET_NEXTPC = 20;
    localparam int BUDGET_STALL  = 30;
    localparam int BUDGET_PREDEC = 50;
    localparam int BUDGET_FULL   = 300;
    localparam int WATCHDOG_CYCLES = 2 * (BUDGET_LOAD + BUDGET_SEQ + BUDGET_NEXTPC
        + BUDGET_STALL + BUDGET_PREDEC + BUDGET_FULL) + RESET_CYCLES;

    logic               clock;
    logic               arstN;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [7:0]         paddr;
    logic [`DATA_W-1:0] pwdata;
    logic [`DATA_W-1:0] prdata;
    logic               pready;
    logic               pslverr;
    logic               pcWrite;
    logic               enable;
    logic               halt;
    logic               flush;
    logic               jumpControl;
    logic [`DATA_W-1:0] jumpAddress;
    logic               branchFlag;
    logic [`DATA_W-1:0] branchAddress;
    logic [`DATA_W-1:0] instruction;
    logic [`DATA_W-1:0] pcResult;
    logic [`DATA_W-1:0] pcPlus4;
    logic               isBranch;
    logic               isJump;
    logic               full;
    logic               empty;
    logic [7:0]         schedPcLsb;
    pcSelT              pcSel;

    int                 errorCount;
    int                 checkCount;
    logic [31:0]        lfsrState;              // Random word source
    logic [31:0]        expPc;                  // PC the tests expect right now
    logic [31:0]        model[$];               // Words the memory should hold

    tbClock u_clock (.o_clock(clock), .o_arstN(arstN));

    ifStage dut (
        .Clock(clock), .i_arstN(arstN),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata),
        .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
        .i_pcWrite(pcWrite), .i_enable(enable), .i_halt(halt), .i_flush(flush),
        .i_jumpControl(jumpControl), .i_jumpAddress(jumpAddress),
        .i_branchFlag(branchFlag), .i_branchAddress(branchAddress),
        .o_instruction(instruction), .o_pcResult(pcResult), .o_pcPlus4(pcPlus4),
        .o_isBranch(isBranch), .o_isJump(isJump), .o_full(full), .o_empty(empty),
        .o_scheduledPcLsb(schedPcLsb), .o_pcSel(pcSel)
    );

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic randomWord(output logic [31:0] word);
        int b;
        word = '0;
        for (b = 0; b < 32; b++) begin
            word = {word[30:0], lfsrState[0]};  // One step per bit
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    // Reference predecode and status layout
    function automatic logic refBranch(input logic [31:0] w);
        return (w[31:26] == OP_BEQ) || (w[31:26] == OP_BNE);
    endfunction

    function automatic logic refJump(input logic [31:0] w);
        return (w[31:26] == OP_J) || (w[31:26] == OP_JAL)
            || ((w[31:26] == OP_RTYPE) && ((w[5:0] == FN_JR) || (w[5:0] == FN_JALR)));
    endfunction

    function automatic logic [31:0] expectedStatus(input int count);
        logic [31:0] s;
        s       = '0;
        s[0]    = (count == `IMEM_DEPTH);       // Full
        s[1]    = (count == 0);                 // Empty
        s[14:8] = count[6:0];
        return s;
    endfunction

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkSel(input string name, input pcSelT exp, input pcSelT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Error %s: expected %s, actual %s (%b)", name, exp.name(), act.name(), act);
        end
    endtask

    // One APB transfer, result taken mid access phase
    task automatic apbTransfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(posedge clock);
        psel    <= 1'b1;                        // Setup phase
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1;                        // Access phase
        @(negedge clock);
        while (!pready) @(negedge clock);       // Watchdog covers a stuck slave
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apbTransfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic flushPc();
        @(posedge clock);
        flush <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;                          // PC cleared at this edge
        expPc = '0;
    endtask

    // Run from PC 0 and compare each fetch with the model
    task automatic fetchAndCheck(input string name, input int cycles);
        logic [31:0] expWord;
        int i;
        flushPc();
        @(posedge clock);
        enable  <= 1'b1;
        pcWrite <= 1'b1;
        for (i = 0; i < cycles; i++) begin
            @(negedge clock);
            expWord = (i < model.size()) ? model[i] : 32'h0;   // NOP past the count
            checkWord({name, " pc"}, 32'(4 * i), pcResult);
            checkWord({name, " instruction"}, expWord, instruction);
            checkBit({name, " isBranch"}, refBranch(expWord), isBranch);
            checkBit({name, " isJump"}, refJump(expWord), isJump);
            @(posedge clock);
        end
        enable  <= 1'b0;
        pcWrite <= 1'b0;
        expPc = 32'(4 * cycles);
    endtask

    task automatic holdCheck(input string name, input logic haltVal,
                             input logic writeVal, input logic runVal);
        @(posedge clock);
        halt    <= haltVal;
        pcWrite <= writeVal;
        enable  <= runVal;
        repeat (3) @(posedge clock);
        @(negedge clock);
        checkWord(name, expPc, pcResult);
    endtask

    task automatic testLoadStatus();
        logic [31:0] data;
        logic [31:0] word;
        logic        err;
        int          n;
        apbRead(`REG_STATUS, data, err);
        checkWord("load status after reset", expectedStatus(0), data);
        for (n = 0; n < 8; n++) begin
            randomWord(word);
            apbWrite(`REG_DATA, word, err);
            checkBit("load push err", 1'b0, err);
            model.push_back(word);
        end
        apbRead(`REG_STATUS, data, err);
        checkWord("load status after 8 words", expectedStatus(model.size()), data);
        @(negedge clock);
        checkBit("load full", 1'b0, full);
        checkBit("load empty", 1'b0, empty);
        apbRead(8'h10, data, err);              // Unmapped offset
        checkWord("load unmapped data", 32'h0, data);
        checkBit("load unmapped err", 1'b1, err);
    endtask

    task automatic testSequentialFetch();
        logic [31:0] data;
        logic        err;
        fetchAndCheck("seqFetch", 10);          // Two fetches past the count
        apbRead(`REG_PC, data, err);
        checkWord("seqFetch REG_PC", expPc, data);
        checkBit("seqFetch REG_PC err", 1'b0, err);
        @(negedge clock);
        checkWord("seqFetch pc", expPc, pcResult);
    endtask

    task automatic testNextPcSelect();
        logic [31:0] jumpAddr;
        logic [31:0] branchAddr;
        logic [31:0] expNext;
        pcSelT       expSel;
        int          k;
        flushPc();
        for (k = 0; k < 4; k++) begin
            jumpAddr   = 32'h0000_1040 + 32'(4 * k);    // Low bytes differ from branch
            branchAddr = 32'h0000_2080 + 32'(4 * k);
            if (k[1]) begin
                expSel  = k[0] ? PC_BRANCH_JUMP : PC_BRANCH;
                expNext = branchAddr;
            end else if (k[0]) begin
                expSel  = PC_JUMP;
                expNext = jumpAddr;
            end else begin
                expSel  = PC_SEQ;
                expNext = expPc + 32'd4;
            end
            @(posedge clock);
            jumpControl   <= k[0];
            branchFlag    <= k[1];
            jumpAddress   <= jumpAddr;
            branchAddress <= branchAddr;
            enable        <= 1'b1;
            pcWrite       <= 1'b1;
            @(negedge clock);
            checkSel("nextPc sel", expSel, pcSel);
            checkWord("nextPc plus4", expPc + 32'd4, pcPlus4);
            checkWord("nextPc scheduled lsb", {24'h0, expNext[7:0]}, {24'h0, schedPcLsb});
            @(posedge clock);                   // PC loads the selected target
            enable      <= 1'b0;
            pcWrite     <= 1'b0;
            jumpControl <= 1'b0;
            branchFlag  <= 1'b0;
            @(negedge clock);
            expPc = expNext;
            checkWord("nextPc pc after edge", expPc, pcResult);
        end
    endtask

    task automatic testStallControls();
        flushPc();
        @(posedge clock);
        enable  <= 1'b1;
        pcWrite <= 1'b1;
        repeat (2) @(posedge clock);            // Two advances
        enable  <= 1'b0;
        pcWrite <= 1'b0;
        expPc = 32'd8;
        @(negedge clock);
        checkWord("stall run", expPc, pcResult);
        holdCheck("stall halt", 1'b1, 1'b1, 1'b1);
        holdCheck("stall write low", 1'b0, 1'b0, 1'b1);
        holdCheck("stall run low", 1'b0, 1'b1, 1'b0);
        @(posedge clock);
        halt    <= 1'b1;                        // Flush must beat halt
        flush   <= 1'b1;
        enable  <= 1'b1;
        pcWrite <= 1'b1;
        @(posedge clock);
        flush <= 1'b0;
        expPc = '0;
        @(negedge clock);
        checkWord("stall flush while halted", expPc, pcResult);
        @(posedge clock);
        halt    <= 1'b0;
        enable  <= 1'b0;
        pcWrite <= 1'b0;
    endtask

    task automatic testPredecode();
        logic [31:0] words [7];
        logic        err;
        int          n;
        // BEQ, BNE, J, JAL, JR, JALR, ADD
        words = '{32'h1085_0003, 32'h1485_FFFE, 32'h0800_0010, 32'h0C00_0020,
                  32'h03E0_0008, 32'h0040_F809, 32'h0085_1020};
        apbWrite(`REG_CTRL, 32'h1, err);
        model.delete();
        checkBit("predecode clear err", 1'b0, err);
        for (n = 0; n < 7; n++) begin
            apbWrite(`REG_DATA, words[n], err);
            checkBit("predecode push err", 1'b0, err);
            model.push_back(words[n]);
        end
        fetchAndCheck("predecode", 7);
    endtask

    task automatic testFullClear();
        logic [31:0] data;
        logic [31:0] word;
        logic        err;
        int          n;
        apbWrite(`REG_CTRL, 32'h1, err);
        model.delete();
        for (n = 0; n < `IMEM_DEPTH; n++) begin
            randomWord(word);
            apbWrite(`REG_DATA, word, err);
            checkBit("fullClear push err", 1'b0, err);
            model.push_back(word);
        end
        @(negedge clock);
        checkBit("fullClear full", 1'b1, full);
        checkBit("fullClear empty", 1'b0, empty);
        randomWord(word);
        apbWrite(`REG_DATA, word, err);         // One word too many
        checkBit("fullClear overflow err", 1'b1, err);
        apbRead(`REG_STATUS, data, err);
        checkWord("fullClear status when full", expectedStatus(model.size()), data);
        apbWrite(`REG_CTRL, 32'h1, err);
        model.delete();
        apbRead(`REG_STATUS, data, err);
        checkWord("fullClear status after clear", expectedStatus(0), data);
        @(negedge clock);
        checkBit("fullClear empty after clear", 1'b1, empty);
        checkBit("fullClear full after clear", 1'b0, full);
        fetchAndCheck("fullClear fetch", 2);    // Cleared memory reads NOPs
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        errorCount    = 0;
        checkCount    = 0;
        lfsrState     = 32'd7;                  // Seed
        expPc         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        pcWrite       = 1'b0;
        enable        = 1'b0;
        halt          = 1'b0;
        flush         = 1'b0;
        jumpControl   = 1'b0;
        jumpAddress   = '0;
        branchFlag    = 1'b0;
        branchAddress = '0;
        @(posedge arstN);
        testLoadStatus();
        testSequentialFetch();
        testNextPcSelect();
        testStallControls();
        testPredecode();
        testFullClear();
        @(posedge clock);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ifStage_asserts.sv
`default_nettype none

module ifStage_asserts (
    input logic        i_clock,
    input logic        i_arstN,
    input logic        i_psel,
    input logic        i_penable,
    input logic        i_pready,
    input logic        i_full,
    input logic        i_empty,
    input logic        i_flush,
    input logic        i_halt,
    input logic [31:0] i_pc
);
    timeunit 1ns;
    timeprecision 1ps;

    // No wait states, every access phase completes
    assert property (@(posedge i_clock) disable iff (!i_arstN)
        (i_psel && i_penable) |-> i_pready)
        else $error("PREADY low during an APB access phase");

    // A memory cannot be full and empty at once
    assert property (@(posedge i_clock) disable iff (!i_arstN) !(i_full && i_empty))
        else $error("Full and empty flags raised together");

    assert property (@(posedge i_clock) disable iff (!i_arstN) i_flush |=> (i_pc == '0))
        else $error("PC not zero one cycle after flush");

    // Halt freezes the PC unless a flush overrides it
    assert property (@(posedge i_clock) disable iff (!i_arstN)
        (i_halt && !i_flush) |=> $stable(i_pc))
        else $error("PC moved while halted");

endmodule

bind ifStage ifStage_asserts u_asserts (
    .i_clock(Clock),
    .i_arstN(i_arstN),
    .i_psel(i_psel),
    .i_penable(i_penable),
    .i_pready(o_pready),
    .i_full(o_full),
    .i_empty(o_empty),
    .i_flush(i_flush),
    .i_halt(i_halt),
    .i_pc(o_pcResult)
);

`default_nettype wire

// File: instructionMemory.sv
`default_nettype none

`include "fetch_params.svh"

module instructionMemory (
    input  logic                  Clock,
    input  logic                  i_arstN,
    input  logic [`DATA_W-1:0]    i_pc,             // Byte address of the fetch
    input  logic                  i_push,           // Append one word
    input  logic [`DATA_W-1:0]    i_pushData,
    input  logic                  i_clear,          // Drop the whole program
    output logic [`DATA_W-1:0]    o_instruction,
    output logic                  o_isBranch,       // Predecoded BEQ or BNE
    output logic                  o_isJump,         // Predecoded J, JAL, JR or JALR
    output logic                  o_full,
    output logic                  o_empty,
    output logic [`IMEM_IDX_W-1:0] o_count          // Words loaded so far
);

    import fetch_pkg::*;

    logic [`DATA_W-1:0]    mem [`IMEM_DEPTH];       // Program storage, no reset
    logic [`IMEM_IDX_W-2:0] wrPtr;                  // Next free slot
    logic [`IMEM_IDX_W-2:0] rdIdx;                  // Word index of the fetch
    logic [`DATA_W-3:0]    wordAddr;                // PC divided by 4
    logic                  inRange;                 // Fetch hits a loaded word
    logic                  pushAccept;
    opcodeT                opcode;
    functT                 funct;

    // Status flags
    assign o_full  = (o_count == `IMEM_DEPTH);
    assign o_empty = (o_count == '0);

    // Write pointer tracks the fill count since words only append
    assign wrPtr      = o_count[`IMEM_IDX_W-2:0];
    assign pushAccept = i_push && !o_full && !i_clear;  // Clear wins, full refuses

    always_ff @(posedge Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            o_count <= '0;
        end else if (i_clear) begin
            o_count <= '0;
        end else if (pushAccept) begin
            o_count <= o_count + 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (pushAccept) begin
            mem[wrPtr] <= i_pushData;
        end
    end

    // Combinational read, beyond the count returns a NOP
    assign wordAddr = i_pc[`DATA_W-1:2];
    assign rdIdx    = i_pc[`IMEM_IDX_W:2];
    assign inRange  = wordAddr < {{(`DATA_W-2-`IMEM_IDX_W){1'b0}}, o_count};

    assign o_instruction = inRange ? mem[rdIdx] : '0;

    // Predecode for the decode stage
    assign opcode = opcodeT'(o_instruction[31:26]);
    assign funct  = functT'(o_instruction[5:0]);

    always_comb begin
        o_isBranch = 1'b0;
        o_isJump   = 1'b0;
        case (opcode)
            OP_BEQ,
            OP_BNE:   o_isBranch = 1'b1;
            OP_J,
            OP_JAL:   o_isJump   = 1'b1;
            OP_RTYPE: o_isJump   = (funct == FN_JR) || (funct == FN_JALR);  // Register jumps
            default:  ;                             // Plain instruction
        endcase
    end

endmodule

`default_nettype wire

// File: nextPcSelect.sv
`default_nettype none

`include "fetch_params.svh"

module nextPcSelect (
    input  logic [`DATA_W-1:0] i_pc,
    input  logic               i_jumpControl,
    input  logic [`DATA_W-1:0] i_jumpAddress,
    input  logic               i_branchFlag,
    input  logic [`DATA_W-1:0] i_branchAddress,
    output logic [`DATA_W-1:0] o_pcPlus4,
    output logic [`DATA_W-1:0] o_pcNext,
    output fetch_pkg::pcSelT   o_pcSel          // Exported for debug
);

    import fetch_pkg::*;

    localparam logic [`DATA_W-1:0] INSTR_BYTES = 4;    // One word per instruction

    assign o_pcPlus4 = i_pc + INSTR_BYTES;
    assign o_pcSel   = pcSelT'({i_branchFlag, i_jumpControl});  // Bit 1 branch, bit 0 jump

    always_comb begin
        case (o_pcSel)
            PC_SEQ:         o_pcNext = o_pcPlus4;
            PC_JUMP:        o_pcNext = i_jumpAddress;
            PC_BRANCH,
            PC_BRANCH_JUMP: o_pcNext = i_branchAddress;    // Branch over jump
            default:        o_pcNext = o_pcPlus4;
        endcase
    end

endmodule

`default_nettype wire

// File: programCounter.sv
`default_nettype none

`include "fetch_params.svh"

module programCounter (
    input  logic               Clock,
    input  logic               i_arstN,
    input  logic               i_pcWrite,       // Hazard unit write enable
    input  logic               i_enable,        // Run enable
    input  logic               i_halt,          // Halt from debug
    input  logic               i_flush,         // Restart fetch at address 0
    input  logic [`DATA_W-1:0] i_pcNext,        // Next PC from the select mux
    output logic [`DATA_W-1:0] o_pc
);

    logic pcLoad;                               // All load conditions met

    // A stall on any of the three controls freezes the PC
    assign pcLoad = i_pcWrite && i_enable && !i_halt;

    always_ff @(posedge Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            o_pc <= '0;
        end else if (i_flush) begin
            o_pc <= '0;                         // Flush beats halt and stall
        end else if (pcLoad) begin
            o_pc <= i_pcNext;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the fetch stage testbench with Verilator, run it, then look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module ifStageTb \
    -f vlog.f -o ifStageSim > build.log 2>&1 \
    && ./obj_dir/ifStageSim > sim.log 2>&1 \
    || echo "Build or simulation step failed, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qs "=== PASS ===" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tbClock.sv
`default_nettype none

module tbClock (
    output logic o_clock,
    output logic o_arstN
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;       // 20 ns clock
    localparam int RESET_CYCLES = 8;

    initial begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD) o_clock = ~o_clock;
    end

    initial begin
        o_arstN = 1'b0;                     // Held low from time zero
        repeat (RESET_CYCLES) @(posedge o_clock);
        o_arstN <= 1'b1;                    // Release on a rising edge
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
fetch_pkg.sv
programCounter.sv
nextPcSelect.sv
instructionMemory.sv
apbLoader.sv
ifStage.sv
tbClock.sv
ifStage_asserts.sv
ifStageTb.sv
